/* all.f */
design/activeListPkg.sv
design/activeListIfs.sv
design/dispatchAllocator.sv
design/entryStore.sv
design/faultTracker.sv
design/retireUnit.sv
design/activeList.sv
dv/activeList_assertions.sv
dv/activeListTb.sv

/* run.sh */
#!/bin/sh
# Compile the active list testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module activeListTb -f all.f &&
./obj_dir/VactiveListTb +verilator+error+limit+1000 | tee /dev/stderr |
    grep -q "^PASS: all tests$" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

/* dv/activeListTb.sv */
//--------------------------------------------------------------------
// Active list testbench
// Random dispatch, out-of-order writeback and commit with flush,
// checked by the bound assertion module
//--------------------------------------------------------------------

`timescale 1ns/10ps

module activeListTb import activeListPkg::*; ();

    localparam int PERIOD          = 100;
    localparam int TEST_CYCLES     = 600;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES * 3 / 2;

    logic                 clk, rst, inValid, wbValid, cmtReady;
    logic                 inReady, cmtValid, cmtFlush;
    logic [PC_WIDTH-1:0]  inPc, cmtPc, cmtRedirectPc;
    logic [PTR_WIDTH-1:0] wbTag, inTag;
    execOutcome_e         wbOutcome;
    wbPayload_u           wbPayload;

    logic [15:0]          lfsr = 16'd45;
    // Tags that are live and not yet written back
    logic [PTR_WIDTH-1:0] pendTags [$];
    int                   liveCount = 0;
    int                   testCount = 0;

    activeList uut (.*);

    bind activeList activeListChecker chk (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [15:0] takeBits(input int n);
        logic [15:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return bits;
    endfunction

    // Accounts for the commit the coming edge takes
    task automatic noteCommit();
        if (cmtValid && cmtReady) begin
            liveCount = cmtFlush ? 0 : liveCount - 1;
            if (cmtFlush) begin
                pendTags.delete();
            end
        end
    endtask

    task automatic dispatchOp(input logic [PC_WIDTH-1:0] pc);
        inValid = 1'b1;
        inPc    = pc;
        while (!inReady) begin
            noteCommit();
            @(negedge clk);
        end
        pendTags.push_back(inTag);
        liveCount++;
        noteCommit();
        @(negedge clk);
        inValid = 1'b0;
    endtask

    task automatic writeback(input int idx, input execOutcome_e outcome, input logic [15:0] word);
        wbValid   = 1'b1;
        wbTag     = pendTags[idx];
        wbOutcome = outcome;
        wbPayload = word;
        pendTags.delete(idx);
        noteCommit();
        @(negedge clk);
        wbValid = 1'b0;
    endtask

    task automatic writebackRandom();
        while (pendTags.size() > 0) begin
            writeback(int'(takeBits(4)) % pendTags.size(), SUCCESS, takeBits(16));
        end
    endtask

    task automatic drainList(input bit randomReady);
        while (liveCount > 0) begin
            cmtReady = randomReady ? (takeBits(1) != 0) : 1'b1;
            noteCommit();
            @(negedge clk);
        end
        cmtReady = 1'b0;
    endtask

    task automatic endTest(input string name);
        testCount++;
        $display("[%0t] test %0d %s done, assertion failures so far %0d",
                 $time, testCount, name, uut.chk.errCount);
    endtask

    initial begin
        rst       = 1'b1;
        inValid   = 1'b0;
        inPc      = '0;
        wbValid   = 1'b0;
        wbTag     = '0;
        wbOutcome = SUCCESS;
        wbPayload = '0;
        cmtReady  = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        endTest("reset state");

        repeat (8) dispatchOp(takeBits(16));
        writebackRandom();
        drainList(1'b1);
        endTest("out of order writeback");

        // Fill the list, then hold a blocked dispatch until one retire
        repeat (ENTRY_NUM) dispatchOp(takeBits(16));
        inValid = 1'b1;
        inPc    = takeBits(16);
        writebackRandom();
        cmtReady = 1'b1;
        noteCommit();
        @(negedge clk);
        cmtReady = 1'b0;
        dispatchOp(inPc);
        writebackRandom();
        drainList(1'b0);
        endTest("full list");

        repeat (2) dispatchOp(takeBits(16));
        writebackRandom();
        repeat (5) @(negedge clk);
        drainList(1'b0);
        endTest("commit stall");

        // Older REDIRECT and younger FAULT, in both writeback orders
        for (int order = 0; order < 2; order++) begin
            repeat (4) dispatchOp(takeBits(16));
            writeback(0, SUCCESS, takeBits(16));
            if (order == 0) begin
                writeback(0, REDIRECT, takeBits(16));
                writeback(0, FAULT, takeBits(16));
            end else begin
                writeback(1, FAULT, takeBits(16));
                writeback(0, REDIRECT, takeBits(16));
            end
            drainList(1'b1);
        end
        endTest("redirect before fault");

        repeat (3) dispatchOp(takeBits(16));
        writeback(1, FAULT, takeBits(16));
        writebackRandom();
        drainList(1'b1);
        dispatchOp(takeBits(16));
        writebackRandom();
        drainList(1'b1);
        endTest("lone fault");

        $display("summary: %0d tests run, %0d assertion failures", testCount, uut.chk.errCount);
        if (uut.chk.errCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("watchdog expired before the tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* dv/activeList_assertions.sv */
//--------------------------------------------------------------------
// Active list checker
// Shadow queue of dispatched ops and concurrent assertions on
// commit order, handshakes and flush, bound onto the active list
//--------------------------------------------------------------------

`timescale 1ns/10ps

module activeListChecker import activeListPkg::*; (
    input logic                 clk, rst, inValid, inReady, wbValid,
    input logic                 cmtValid, cmtReady, cmtFlush,
    input logic [PC_WIDTH-1:0]  inPc, cmtPc, cmtRedirectPc,
    input logic [PTR_WIDTH-1:0] inTag, wbTag,
    input execOutcome_e         wbOutcome,
    input wbPayload_u           wbPayload
);

    int errCount = 0;

    // Shadow queue in dispatch order
    logic [PC_WIDTH-1:0]  shPc [ENTRY_NUM];
    logic [PTR_WIDTH-1:0] shTag [ENTRY_NUM];
    logic [PTR_WIDTH-1:0] rdIdx;
    logic [PTR_WIDTH-1:0] wrIdx;
    int                   shCount;

    // Writeback results by tag
    logic [ENTRY_NUM-1:0] shDone;
    execOutcome_e         shOutcome [ENTRY_NUM];
    wbPayload_u           shPayload [ENTRY_NUM];

    logic                 push;
    logic                 retire;
    logic [PTR_WIDTH-1:0] headTag;
    logic [PTR_WIDTH-1:0] expTag;
    logic                 expValid;
    logic                 expFlush;
    logic [PC_WIDTH-1:0]  expPc;
    logic [PC_WIDTH-1:0]  expRedirect;

    task automatic flagError(input string msg);
        $error("%s", msg);
        errCount++;
    endtask

    assign push    = inValid && inReady;
    assign retire  = cmtValid && cmtReady;
    assign headTag = shTag[rdIdx];
    assign expPc   = shPc[rdIdx];

    // A finished head with a recovery outcome is always the oldest one
    assign expValid    = (shCount != 0) && shDone[headTag];
    assign expFlush    = expValid && (shOutcome[headTag] != SUCCESS);
    assign expRedirect = (shOutcome[headTag] == REDIRECT) ? shPayload[headTag].target
                                                          : HANDLER_PC;

    always_ff @(posedge clk) begin
        if (rst) begin
            rdIdx   <= '0;
            wrIdx   <= '0;
            shCount <= 0;
            shDone  <= '0;
            expTag  <= '0;
        end else if (retire && cmtFlush) begin
            rdIdx   <= wrIdx;
            shCount <= 0;
            shDone  <= '0;
            // Next tag follows the flushed head
            expTag  <= headTag + PTR_WIDTH'(1);
        end else begin
            if (push) begin
                shPc[wrIdx]    <= inPc;
                shTag[wrIdx]   <= expTag;
                wrIdx          <= wrIdx + PTR_WIDTH'(1);
                shDone[expTag] <= 1'b0;
                expTag         <= expTag + PTR_WIDTH'(1);
            end
            if (wbValid) begin
                shDone[wbTag]    <= 1'b1;
                shOutcome[wbTag] <= wbOutcome;
                shPayload[wbTag] <= wbPayload;
            end
            if (retire) begin
                rdIdx <= rdIdx + PTR_WIDTH'(1);
            end
            shCount <= shCount + int'(push) - int'(retire);
        end
    end

    resetState: assert property (@(posedge clk) $fell(rst) |-> !cmtValid && !cmtFlush && inReady)
        else flagError("list not empty and ready right after reset");

    tagMatch: assert property (@(posedge clk) disable iff (rst) inTag == expTag)
        else flagError($sformatf("[FAIL] %0t inTag got %h expected %h", $time, inTag, expTag));

    commitOrder: assert property (@(posedge clk) disable iff (rst)
        retire |-> cmtPc == expPc)
        else flagError($sformatf("[FAIL] %0t cmtPc got %h expected %h", $time, cmtPc, expPc));

    validMatch: assert property (@(posedge clk) disable iff (rst) cmtValid == expValid)
        else flagError($sformatf("[FAIL] %0t cmtValid got %b expected %b",
                                 $time, cmtValid, expValid));

    // Full list or pending flush blocks dispatch
    readyMatch: assert property (@(posedge clk) disable iff (rst)
        inReady == (shCount < ENTRY_NUM && !expFlush))
        else flagError($sformatf("[FAIL] %0t inReady got %b expected %b", $time, inReady,
                                 shCount < ENTRY_NUM && !expFlush));

    flushMatch: assert property (@(posedge clk) disable iff (rst) cmtFlush == expFlush)
        else flagError($sformatf("[FAIL] %0t cmtFlush got %b expected %b",
                                 $time, cmtFlush, expFlush));

    redirectMatch: assert property (@(posedge clk) disable iff (rst)
        cmtFlush |-> cmtRedirectPc == expRedirect)
        else flagError($sformatf("[FAIL] %0t cmtRedirectPc got %h expected %h",
                                 $time, cmtRedirectPc, expRedirect));

    holdWhileStalled: assert property (@(posedge clk) disable iff (rst)
        cmtValid && !cmtReady |=> cmtValid && $stable(cmtPc))
        else flagError("head changed or dropped while commit was stalled");

    emptyAfterFlush: assert property (@(posedge clk) disable iff (rst)
        cmtFlush && cmtReady |=> !cmtValid && inReady)
        else flagError("list not empty and ready in the cycle after a flush");

endmodule

/* design/activeList.sv */
//--------------------------------------------------------------------
// Active list top level
// 16-entry in-order reorder buffer with dispatch, writeback,
// commit and flush on the oldest recovery outcome
//--------------------------------------------------------------------

`timescale 1ns/10ps

module activeList import activeListPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    // Dispatch
    input  logic                 inValid,
    input  logic [PC_WIDTH-1:0]  inPc,
    output logic                 inReady,
    output logic [PTR_WIDTH-1:0] inTag,
    // Writeback
    input  logic                 wbValid,
    input  logic [PTR_WIDTH-1:0] wbTag,
    input  execOutcome_e         wbOutcome,
    input  wbPayload_u           wbPayload,
    // Commit
    output logic                 cmtValid,
    input  logic                 cmtReady,
    output logic [PC_WIDTH-1:0]  cmtPc,
    output logic                 cmtFlush,
    output logic [PC_WIDTH-1:0]  cmtRedirectPc
);

    allocIf  allocBus ();
    retireIf retireBus ();
    faultIf  faultBus ();

    dispatchAllocator allocator (
        .clk(clk), .rst(rst),
        .inValid(inValid), .inPc(inPc), .inReady(inReady), .inTag(inTag),
        .alloc(allocBus.source), .retire(retireBus.monitor)
    );

    entryStore store (
        .clk(clk), .rst(rst),
        .alloc(allocBus.sink), .retire(retireBus.store),
        .wbValid(wbValid), .wbTag(wbTag)
    );

    faultTracker tracker (
        .clk(clk), .rst(rst),
        .wbValid(wbValid), .wbTag(wbTag), .wbOutcome(wbOutcome), .wbPayload(wbPayload),
        .retire(retireBus.monitor), .fault(faultBus.source)
    );

    retireUnit retirer (
        .clk(clk), .rst(rst),
        .cmtValid(cmtValid), .cmtReady(cmtReady), .cmtPc(cmtPc),
        .cmtFlush(cmtFlush), .cmtRedirectPc(cmtRedirectPc),
        .retire(retireBus.driver), .fault(faultBus.sink)
    );

endmodule

/* design/retireUnit.sv */
//--------------------------------------------------------------------
// Retire unit
// Head pointer, in-order commit handshake and flush with the
// redirect target of the recorded outcome
//--------------------------------------------------------------------

`timescale 1ns/10ps

module retireUnit import activeListPkg::*; (
    input  logic                clk,
    input  logic                rst,
    output logic                cmtValid,
    input  logic                cmtReady,
    output logic [PC_WIDTH-1:0] cmtPc,
    output logic                cmtFlush,
    output logic [PC_WIDTH-1:0] cmtRedirectPc,
    retireIf.driver             retire,
    faultIf.sink                fault
);

    logic [PTR_WIDTH-1:0] headPtr;

    // headDone is only set for live entries, so it also covers empty
    assign cmtValid = retire.headDone;
    assign cmtPc    = retire.headPc;

    // Head is the op that recorded the recovery outcome
    assign cmtFlush = cmtValid && fault.faultValid && (fault.faultPtr == headPtr);

    // Payload word decoded by outcome
    always_comb begin
        case (fault.faultOutcome)
            REDIRECT: cmtRedirectPc = fault.faultPayload.target;
            FAULT:    cmtRedirectPc = HANDLER_PC;
            default:  cmtRedirectPc = HANDLER_PC;
        endcase
    end

    assign retire.headPtr = headPtr;
    assign retire.pop     = cmtValid && cmtReady;
    assign retire.flush   = cmtFlush;

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
        end else if (retire.pop) begin
            headPtr <= headPtr + PTR_WIDTH'(1);
        end
    end

endmodule

/* design/faultTracker.sv */
//--------------------------------------------------------------------
// Fault tracker
// Keeps the oldest writeback outcome that needs recovery, ordered
// by age relative to the head of the list
//--------------------------------------------------------------------

`timescale 1ns/10ps

module faultTracker import activeListPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wbValid,
    input  logic [PTR_WIDTH-1:0] wbTag,
    input  execOutcome_e         wbOutcome,
    input  wbPayload_u           wbPayload,
    retireIf.monitor             retire,
    faultIf.source               fault
);

    logic                 recValid;
    logic [PTR_WIDTH-1:0] recPtr;
    execOutcome_e         recOutcome;
    wbPayload_u           recPayload;

    logic [PTR_WIDTH-1:0] wbAge;
    logic [PTR_WIDTH-1:0] recAge;
    logic                 record;

    // Age is the distance from the head, wrapping mod 16
    assign wbAge  = wbTag - retire.headPtr;
    assign recAge = recPtr - retire.headPtr;

    // Take the new outcome if nothing is held or it is older
    assign record = wbValid && (wbOutcome != SUCCESS) &&
                    (!recValid || (wbAge < recAge));

    always_ff @(posedge clk) begin
        if (rst) begin
            recValid <= 1'b0;
        end else if (retire.pop && retire.flush) begin
            recValid <= 1'b0;
        end else if (record) begin
            recValid <= 1'b1;
        end
    end

    // Payload side, qualified by recValid
    always_ff @(posedge clk) begin
        if (record) begin
            recPtr     <= wbTag;
            recOutcome <= wbOutcome;
            recPayload <= wbPayload;
        end
    end

    assign fault.faultValid   = recValid;
    assign fault.faultPtr     = recPtr;
    assign fault.faultOutcome = recOutcome;
    assign fault.faultPayload = recPayload;

endmodule

/* design/entryStore.sv */
//--------------------------------------------------------------------
// Entry store
// PC RAM and per-entry done bits, with a combinational read of
// the head entry
//--------------------------------------------------------------------

`timescale 1ns/10ps

module entryStore import activeListPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    allocIf.sink                 alloc,
    retireIf.store               retire,
    input  logic                 wbValid,
    input  logic [PTR_WIDTH-1:0] wbTag
);

    logic [PC_WIDTH-1:0]  pcRam [ENTRY_NUM];
    logic [ENTRY_NUM-1:0] doneBits;

    always_ff @(posedge clk) begin
        if (alloc.push) begin
            pcRam[alloc.pushPtr] <= alloc.pushPc;
        end
    end

    // A retired entry drops its done bit, so a set bit at the
    // head always means a live, finished op
    always_ff @(posedge clk) begin
        if (rst) begin
            doneBits <= '0;
        end else if (retire.pop && retire.flush) begin
            doneBits <= '0;
        end else begin
            if (retire.pop) begin
                doneBits[retire.headPtr] <= 1'b0;
            end
            if (alloc.push) begin
                doneBits[alloc.pushPtr] <= 1'b0;
            end
            if (wbValid) begin
                doneBits[wbTag] <= 1'b1;
            end
        end
    end

    // Head read
    assign retire.headPc   = pcRam[retire.headPtr];
    assign retire.headDone = doneBits[retire.headPtr];

endmodule

/* design/dispatchAllocator.sv */
//--------------------------------------------------------------------
// Dispatch allocator
// Owns the tail pointer and the occupancy count and accepts
// single-lane dispatch into the active list
//--------------------------------------------------------------------

`timescale 1ns/10ps

module dispatchAllocator import activeListPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inValid,
    input  logic [PC_WIDTH-1:0]  inPc,
    output logic                 inReady,
    output logic [PTR_WIDTH-1:0] inTag,
    allocIf.source               alloc,
    retireIf.monitor             retire
);

    logic [PTR_WIDTH-1:0]   tailPtr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   full;

    assign full = (count == COUNT_WIDTH'(ENTRY_NUM));

    // Hold off dispatch while the head is about to flush the list
    assign inReady = !full && !retire.flush;
    assign inTag   = tailPtr;

    assign alloc.push    = inValid && inReady;
    assign alloc.pushPtr = tailPtr;
    assign alloc.pushPc  = inPc;

    always_ff @(posedge clk) begin
        if (rst) begin
            tailPtr <= '0;
            count   <= '0;
        end else if (retire.pop && retire.flush) begin
            // List empties, tail follows the advancing head
            tailPtr <= retire.headPtr + PTR_WIDTH'(1);
            count   <= '0;
        end else begin
            if (alloc.push) begin
                tailPtr <= tailPtr + PTR_WIDTH'(1);
            end
            count <= count + COUNT_WIDTH'(alloc.push) - COUNT_WIDTH'(retire.pop);
        end
    end

endmodule

/* design/activeListIfs.sv */
//--------------------------------------------------------------------
// Active list internal interfaces
// Allocation, retire and fault channels between the list blocks
//--------------------------------------------------------------------

`timescale 1ns/10ps

// Push of a new entry at the tail
interface allocIf import activeListPkg::*; ();
    logic                 push;
    logic [PTR_WIDTH-1:0] pushPtr;
    logic [PC_WIDTH-1:0]  pushPc;

    modport source (output push, pushPtr, pushPc);
    modport sink   (input  push, pushPtr, pushPc);
endinterface

// Head state and commit events
// flush is high while the head carries the recorded outcome,
// so a flush retire is pop and flush together
interface retireIf import activeListPkg::*; ();
    logic                 pop;
    logic                 flush;
    logic [PTR_WIDTH-1:0] headPtr;
    logic [PC_WIDTH-1:0]  headPc;
    logic                 headDone;

    modport driver  (output headPtr, pop, flush, input headPc, headDone);
    modport store   (input headPtr, pop, flush, output headPc, headDone);
    modport monitor (input headPtr, pop, flush);
endinterface

// Oldest outcome that needs recovery
interface faultIf import activeListPkg::*; ();
    logic                 faultValid;
    logic [PTR_WIDTH-1:0] faultPtr;
    execOutcome_e         faultOutcome;
    wbPayload_u           faultPayload;

    modport source (output faultValid, faultPtr, faultOutcome, faultPayload);
    modport sink   (input  faultValid, faultPtr, faultOutcome, faultPayload);
endinterface

/* design/activeListPkg.sv */
//--------------------------------------------------------------------
// Active list package
// Sizes, the writeback outcome type and the writeback payload union
// shared by every block of the reorder buffer
//--------------------------------------------------------------------

package activeListPkg;

    // Entry count and index widths
    localparam int ENTRY_NUM   = 16;
    localparam int PTR_WIDTH   = 4;
    localparam int COUNT_WIDTH = 5;

    localparam int PC_WIDTH = 16;

    // Where a memory fault sends the front end
    localparam logic [PC_WIDTH-1:0] HANDLER_PC = 16'h0100;

    // Result of execution for one entry
    typedef enum logic [1:0] {
        SUCCESS  = 2'd0,
        REDIRECT = 2'd1,
        FAULT    = 2'd2
    } execOutcome_e;

    // Fault view of the payload word
    typedef struct packed {
        logic [3:0]  cause;
        logic [11:0] dataAddr;
    } faultInfo_t;

    // One payload word, read by outcome
    typedef union packed {
        logic [PC_WIDTH-1:0] target;
        faultInfo_t          fault;
    } wbPayload_u;

endpackage
